/* cpuPkg.sv */
package cpuPkg;

  // machine word and register index widths
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int numRegs      = 1 << regAddrWidth;

  // next-PC select codes for ctrlT.pcSrc
  localparam logic [1:0] pcSrcPlus4  = 2'd0;
  localparam logic [1:0] pcSrcBranch = 2'd1;
  localparam logic [1:0] pcSrcJump   = 2'd2;

  // major opcodes, MIPS encoding
  typedef enum logic [5:0] {
    opRType = 6'h00,
    opJ     = 6'h02,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  // R-type function field
  typedef enum logic [5:0] {
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOpT;

  typedef enum logic [3:0] {
    stReset,
    stFetchReq,
    stFetchRel,
    stDecode,
    stExecute,
    stMemReq,
    stMemRel,
    stWriteBack,
    stHalt
  } cpuStateT;

  // load enables and selects, control unit to datapath
  typedef struct packed {
    logic       pcLoad;
    logic       irLoad;
    logic       marLoad;
    logic       mdrLoad;
    logic       abLoad;
    logic       aluOutLoad;
    logic       regWrite;
    logic       regDstRd;
    logic       memToReg;
    logic       aluSrcImm;
    logic       marFromAlu;
    logic [1:0] pcSrc;
    aluOpT      aluOp;
  } ctrlT;

  // held stable for the whole time req is high
  typedef struct packed {
    logic [dataWidth-1:0] addr;
    logic [dataWidth-1:0] wdata;
    logic                 write;
  } memReqT;

endpackage

/* aluUnit.sv */
`timescale 1ns/10ps

module aluUnit (
  input  cpuPkg::aluOpT                 op,
  input  logic [cpuPkg::dataWidth-1:0] a,
  input  logic [cpuPkg::dataWidth-1:0] b,
  output logic [cpuPkg::dataWidth-1:0] result,
  output logic                          zero
);
  import cpuPkg::*;

  logic lessSigned;

  // signed compare for SLT
  assign lessSigned = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      aluAdd: begin
        result = a + b;
      end
      aluSub: begin
        result = a - b;
      end
      aluAnd: begin
        result = a & b;
      end
      aluOr: begin
        result = a | b;
      end
      aluSlt: begin
        result = {{(dataWidth-1){1'b0}}, lessSigned};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // equality for BEQ, taken from the subtract
  assign zero = (result == '0);

endmodule

/* regFile.sv */
`timescale 1ns/10ps

module regFile (
  input  logic                             Clk,
  input  logic                             rstN,
  input  logic [cpuPkg::regAddrWidth-1:0] rdAddrA,
  input  logic [cpuPkg::regAddrWidth-1:0] rdAddrB,
  input  logic [cpuPkg::regAddrWidth-1:0] wrAddr,
  input  logic                             wrEn,
  input  logic [cpuPkg::dataWidth-1:0]    wrData,
  output logic [cpuPkg::dataWidth-1:0]    rdDataA,
  output logic [cpuPkg::dataWidth-1:0]    rdDataB
);
  import cpuPkg::*;

  logic [dataWidth-1:0] regs [numRegs];

  // writes to r0 dropped, so it stays zero from reset
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // asynchronous read ports
  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];

endmodule

/* controlUnit.sv */
`timescale 1ns/10ps

module controlUnit (
  input  logic           Clk,
  input  logic           rstN,
  input  cpuPkg::opcodeT opcode,
  input  cpuPkg::functT  funct,
  input  logic           aluZero,
  input  logic           memAck,
  output logic           memReq,
  output logic           memWrite,
  output cpuPkg::ctrlT   ctrl,
  output logic           halted
);
  import cpuPkg::*;

  cpuStateT state;
  cpuStateT nextState;
  logic     instrLegal;

  // R-type function field to ALU operation
  function automatic aluOpT functToAluOp(input functT fn);
    case (fn)
      fnSub:   return aluSub;
      fnAnd:   return aluAnd;
      fnOr:    return aluOr;
      fnSlt:   return aluSlt;
      default: return aluAdd;
    endcase
  endfunction

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      state <= stReset;
    end else begin
      state <= nextState;
    end
  end

  // anything outside the subset traps
  always_comb begin
    case (opcode)
      opRType:                       instrLegal = funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt};
      opAddi, opLw, opSw, opBeq, opJ: instrLegal = 1'b1;
      default:                       instrLegal = 1'b0;
    endcase
  end

  always_comb begin
    ctrl       = '0;
    ctrl.pcSrc = pcSrcPlus4;
    ctrl.aluOp = aluAdd;
    nextState  = state;
    case (state)
      stReset: nextState = stFetchReq;
      stFetchReq: begin
        // ack cycle: capture instruction, step PC
        if (memAck) begin
          ctrl.irLoad = 1'b1;
          ctrl.pcLoad = 1'b1;
          nextState   = stFetchRel;
        end
      end
      stFetchRel: begin
        if (!memAck) nextState = stDecode;
      end
      stDecode: begin
        ctrl.abLoad = 1'b1;
        nextState   = instrLegal ? stExecute : stHalt;
      end
      stExecute: begin
        case (opcode)
          opRType: begin
            ctrl.aluOp      = functToAluOp(funct);
            ctrl.aluOutLoad = 1'b1;
            nextState       = stWriteBack;
          end
          opAddi: begin
            ctrl.aluSrcImm  = 1'b1;
            ctrl.aluOutLoad = 1'b1;
            nextState       = stWriteBack;
          end
          opBeq: begin
            // compare, then point MAR at the next fetch
            ctrl.aluOp   = aluSub;
            ctrl.pcSrc   = pcSrcBranch;
            ctrl.pcLoad  = aluZero;
            ctrl.marLoad = 1'b1;
            nextState    = stFetchReq;
          end
          opJ: begin
            ctrl.pcSrc   = pcSrcJump;
            ctrl.pcLoad  = 1'b1;
            ctrl.marLoad = 1'b1;
            nextState    = stFetchReq;
          end
          default: begin
            // LW and SW, effective address straight into MAR
            ctrl.aluSrcImm  = 1'b1;
            ctrl.marLoad    = 1'b1;
            ctrl.marFromAlu = 1'b1;
            nextState       = stMemReq;
          end
        endcase
      end
      stMemReq: begin
        if (memAck) begin
          ctrl.mdrLoad = (opcode == opLw);
          nextState    = stMemRel;
        end
      end
      stMemRel: begin
        if (!memAck) begin
          if (opcode == opLw) begin
            nextState = stWriteBack;
          end else begin
            // store done, refetch from PC
            ctrl.marLoad = 1'b1;
            nextState    = stFetchReq;
          end
        end
      end
      stWriteBack: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDstRd = (opcode == opRType);
        ctrl.memToReg = (opcode == opLw);
        ctrl.marLoad  = 1'b1;
        nextState     = stFetchReq;
      end
      default: nextState = stHalt;
    endcase
  end

  assign memReq   = (state == stFetchReq) || (state == stMemReq);
  assign memWrite = (state == stMemReq) && (opcode == opSw);
  assign halted   = (state == stHalt);

  // four-phase rules on the memory port
  reqHeldUntilAck: assert property (@(posedge Clk) disable iff (!rstN)
    $fell(memReq) |-> $past(memAck));

  reqAfterAckLow: assert property (@(posedge Clk) disable iff (!rstN)
    $rose(memReq) |-> !$past(memAck));

endmodule

/* cpuDatapath.sv */
`timescale 1ns/10ps

module cpuDatapath (
  input  logic                          Clk,
  input  logic                          rstN,
  input  cpuPkg::ctrlT                  ctrl,
  input  logic                          memWrite,
  input  logic [cpuPkg::dataWidth-1:0] memRdata,
  output cpuPkg::memReqT                memCmd,
  output cpuPkg::opcodeT                opcode,
  output cpuPkg::functT                 funct,
  output logic                          aluZero
);
  import cpuPkg::*;

  logic [dataWidth-1:0]    pc;
  logic [dataWidth-1:0]    ir;
  logic [dataWidth-1:0]    mar;
  logic [dataWidth-1:0]    mdr;
  logic [dataWidth-1:0]    regA;
  logic [dataWidth-1:0]    regB;
  logic [dataWidth-1:0]    aluOut;
  logic [dataWidth-1:0]    rdDataA;
  logic [dataWidth-1:0]    rdDataB;
  logic [dataWidth-1:0]    signExt;
  logic [dataWidth-1:0]    aluB;
  logic [dataWidth-1:0]    aluResult;
  logic [dataWidth-1:0]    pcTarget;
  logic [dataWidth-1:0]    pcNew;
  logic [dataWidth-1:0]    wrData;
  logic [regAddrWidth-1:0] wrAddr;

  // instruction fields
  assign opcode  = opcodeT'(ir[31:26]);
  assign funct   = functT'(ir[5:0]);
  assign signExt = {{16{ir[15]}}, ir[15:0]};

  // operand B: register or immediate
  assign aluB = ctrl.aluSrcImm ? signExt : regB;

  // next PC; PC already holds PC+4 once decode starts
  always_comb begin
    case (ctrl.pcSrc)
      pcSrcBranch: pcTarget = pc + (signExt << 2);
      pcSrcJump:   pcTarget = {pc[31:28], ir[25:0], 2'b00};
      default:     pcTarget = pc + 32'd4;
    endcase
  end

  // value PC holds after this edge, fed to MAR for the next fetch
  assign pcNew = ctrl.pcLoad ? pcTarget : pc;

  // write-back: rd for R-type, rt otherwise
  assign wrAddr = ctrl.regDstRd ? ir[15:11] : ir[20:16];
  assign wrData = ctrl.memToReg ? mdr : aluOut;

  regFile regs (
    .Clk     (Clk),
    .rstN    (rstN),
    .rdAddrA (ir[25:21]),
    .rdAddrB (ir[20:16]),
    .wrAddr  (wrAddr),
    .wrEn    (ctrl.regWrite),
    .wrData  (wrData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  aluUnit alu (
    .op     (ctrl.aluOp),
    .a      (regA),
    .b      (aluB),
    .result (aluResult),
    .zero   (aluZero)
  );

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      pc     <= '0;
      ir     <= '0;
      mar    <= '0;
      mdr    <= '0;
      regA   <= '0;
      regB   <= '0;
      aluOut <= '0;
    end else begin
      if (ctrl.pcLoad) pc <= pcTarget;
      if (ctrl.irLoad) ir <= memRdata;
      if (ctrl.marLoad) mar <= ctrl.marFromAlu ? aluResult : pcNew;
      if (ctrl.mdrLoad) mdr <= memRdata;
      if (ctrl.abLoad) begin
        regA <= rdDataA;
        regB <= rdDataB;
      end
      if (ctrl.aluOutLoad) aluOut <= aluResult;
    end
  end

  // request fields, wdata from B
  assign memCmd = '{addr: mar, wdata: regB, write: memWrite};

  // instruction always fetched from the PC address
  fetchFromPc: assert property (@(posedge Clk) disable iff (!rstN)
    ctrl.irLoad |-> (mar == pc));

  // store request held steady until released
  storeCmdStable: assert property (@(posedge Clk) disable iff (!rstN)
    memWrite && $past(memWrite) |-> $stable(memCmd));

endmodule

/* cpuTop.sv */
`timescale 1ns/10ps

module cpuTop (
  input  logic                          Clk,
  input  logic                          rstN,
  output logic                          memReq,
  output cpuPkg::memReqT                memCmd,
  input  logic                          memAck,
  input  logic [cpuPkg::dataWidth-1:0] memRdata,
  output logic                          halted
);
  import cpuPkg::*;

  ctrlT   ctrl;
  opcodeT opcode;
  functT  funct;
  logic   aluZero;
  logic   memWrite;

  // sequencing and handshake
  controlUnit ctrlUnit (
    .Clk      (Clk),
    .rstN     (rstN),
    .opcode   (opcode),
    .funct    (funct),
    .aluZero  (aluZero),
    .memAck   (memAck),
    .memReq   (memReq),
    .memWrite (memWrite),
    .ctrl     (ctrl),
    .halted   (halted)
  );

  // registers, ALU and request fields
  cpuDatapath datapath (
    .Clk      (Clk),
    .rstN     (rstN),
    .ctrl     (ctrl),
    .memWrite (memWrite),
    .memRdata (memRdata),
    .memCmd   (memCmd),
    .opcode   (opcode),
    .funct    (funct),
    .aluZero  (aluZero)
  );

endmodule

/* tbMemory.sv */
`timescale 1ns/10ps

module tbMemory (
  input  logic                          Clk,
  input  logic                          memReq,
  input  cpuPkg::memReqT                memCmd,
  input  int                            maxDelay,
  output logic                          memAck,
  output logic [cpuPkg::dataWidth-1:0] memRdata
);
  import cpuPkg::*;

  localparam int logDepth = 64;

  // unified word memory, byte addresses
  logic [dataWidth-1:0] words [1024];
  // store log read by the testbench top
  logic [dataWidth-1:0] storeAddr [logDepth];
  logic [dataWidth-1:0] storeData [logDepth];
  int                   storeCount;
  memReqT               cmd;

  // lands 2 ns after each rising edge
  task automatic waitCycles(input int n);
    repeat (n) begin
      @(posedge Clk);
      #2;
    end
  endtask

  initial begin
    memAck   = 1'b0;
    memRdata = '0;
    forever begin
      waitCycles(1);
      if (memReq) begin
        // random latency before the ack
        waitCycles($urandom_range(maxDelay, 0));
        cmd = memCmd;
        if (cmd.write) begin
          words[cmd.addr[11:2]] = cmd.wdata;
          if (storeCount < logDepth) begin
            storeAddr[storeCount[5:0]] = cmd.addr;
            storeData[storeCount[5:0]] = cmd.wdata;
          end
          storeCount++;
        end else begin
          memRdata = words[cmd.addr[11:2]];
        end
        memAck = 1'b1;
        // ack held until req drops
        do begin
          waitCycles(1);
        end while (memReq);
        waitCycles($urandom_range(maxDelay, 0));
        memAck = 1'b0;
      end
    end
  end

endmodule

/* tbCpu.sv */
`timescale 1ns/10ps

module tbCpu;
  import cpuPkg::*;

  // opcode 0x3f is outside the subset
  localparam logic [31:0] trapWord = 32'hfc00_0000;
  // about 60 instructions, ~32 cycles each at delay 6, doubled, plus resets
  localparam int timeoutCycles = 2 * 60 * 32 + 160;

  logic                 Clk;
  logic                 rstN;
  logic                 memReq;
  memReqT               memCmd;
  logic                 memAck;
  logic [dataWidth-1:0] memRdata;
  logic                 halted;
  int                   maxDelay;
  int                   errorCount;
  int                   checkCount;
  int                   cycles;
  int                   progLen;
  logic [31:0]          expAddr[$];
  logic [31:0]          expData[$];
  logic                 reqHeld;
  memReqT               heldCmd;

  cpuTop uut (
    .Clk      (Clk),
    .rstN     (rstN),
    .memReq   (memReq),
    .memCmd   (memCmd),
    .memAck   (memAck),
    .memRdata (memRdata),
    .halted   (halted)
  );

  tbMemory mem (
    .Clk      (Clk),
    .memReq   (memReq),
    .memCmd   (memCmd),
    .maxDelay (maxDelay),
    .memAck   (memAck),
    .memRdata (memRdata)
  );

  initial Clk = 1'b0;
  always #20 Clk = ~Clk;

  task automatic checkWord(input string name, input logic [dataWidth-1:0] got, exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkAddr(input string name, input logic [dataWidth-1:0] got, exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic checkStoreCount(input int got, exp);
    checkCount++;
    if (got != exp) begin
      errorCount++;
      $display("[FAIL] storeCount: got 0x%0h, expected 0x%0h", got, exp);
    end
  endtask

  // instruction assembly, MIPS field layout
  function automatic logic [31:0] rTypeWord(input logic [4:0] rs, rt, rd, input functT fn);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iTypeWord(input opcodeT op, input logic [4:0] rs, rt,
                                            input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jumpWord(input logic [31:0] target);
    return {opJ, target[27:2]};
  endfunction

  task automatic stepCycle();
    @(posedge Clk);
    #2;
  endtask

  task automatic emit(input logic [31:0] word);
    mem.words[progLen[9:0]] = word;
    progLen++;
  endtask

  task automatic poke(input logic [31:0] addr, data);
    mem.words[addr[11:2]] = data;
  endtask

  task automatic expectStore(input logic [31:0] addr, data);
    expAddr.push_back(addr);
    expData.push_back(data);
  endtask

  // core held in reset while memory is refilled
  task automatic holdReset();
    stepCycle();
    rstN = 1'b0;
    // stray fetches decode as traps
    for (int i = 0; i < 1024; i++) begin
      mem.words[i[9:0]] = trapWord | (i << 2);
    end
    mem.storeCount = 0;
    progLen = 0;
    expAddr.delete();
    expData.delete();
  endtask

  task automatic releaseReset();
    repeat (2) stepCycle();
    rstN = 1'b1;
  endtask

  task automatic runUntilHalted();
    while (!halted) stepCycle();
  endtask

  task automatic compareStoreLog();
    checkStoreCount(mem.storeCount, expAddr.size());
    for (int i = 0; i < expAddr.size() && i < mem.storeCount; i++) begin
      checkAddr($sformatf("store[%0d].addr", i), mem.storeAddr[i[5:0]], expAddr[i]);
      checkWord($sformatf("store[%0d].data", i), mem.storeData[i[5:0]], expData[i]);
    end
  endtask

  // memCmd frozen for as long as req stays high
  always @(negedge Clk) begin
    if (rstN && memReq) begin
      if (reqHeld) begin
        checkAddr("memCmd.addr", memCmd.addr, heldCmd.addr);
        checkWord("memCmd.wdata", memCmd.wdata, heldCmd.wdata);
        checkBit("memCmd.write", memCmd.write, heldCmd.write);
      end
      heldCmd = memCmd;
    end
    reqHeld = rstN && memReq;
  end

  always @(posedge Clk) begin
    cycles++;
    if (cycles >= timeoutCycles) begin
      $display("timeout: core did not halt within %0d cycles", timeoutCycles);
      $display("Checks failed");
      $finish;
    end
  end

  task automatic resetAndFirstFetch();
    holdReset();
    emit(trapWord);
    releaseReset();
    checkBit("memReq", memReq, 1'b0);
    checkBit("halted", halted, 1'b0);
    while (!memReq) stepCycle();
    checkAddr("memCmd.addr", memCmd.addr, 32'h0);
    checkBit("memCmd.write", memCmd.write, 1'b0);
    runUntilHalted();
    compareStoreLog();
  endtask

  task automatic arithmeticOps();
    int a;
    int b;
    int c;
    a = 100;
    b = 7;
    c = -5;
    holdReset();
    emit(iTypeWord(opAddi, 5'd0, 5'd1, 16'd100));
    emit(iTypeWord(opAddi, 5'd0, 5'd2, 16'd7));
    emit(iTypeWord(opAddi, 5'd0, 5'd3, -16'sd5));
    emit(rTypeWord(5'd1, 5'd2, 5'd4, fnAdd));
    emit(rTypeWord(5'd2, 5'd1, 5'd5, fnSub));
    emit(rTypeWord(5'd1, 5'd2, 5'd6, fnAnd));
    emit(rTypeWord(5'd1, 5'd2, 5'd7, fnOr));
    // signed compare both ways round
    emit(rTypeWord(5'd3, 5'd2, 5'd8, fnSlt));
    emit(rTypeWord(5'd2, 5'd3, 5'd9, fnSlt));
    for (int r = 4; r <= 9; r++) begin
      emit(iTypeWord(opSw, 5'd0, 5'(r), 16'(32'h200 + 4 * (r - 4))));
    end
    emit(trapWord);
    expectStore(32'h200, a + b);
    expectStore(32'h204, b - a);
    expectStore(32'h208, a & b);
    expectStore(32'h20c, a | b);
    expectStore(32'h210, (c < b) ? 1 : 0);
    expectStore(32'h214, (b < c) ? 1 : 0);
    releaseReset();
    runUntilHalted();
    compareStoreLog();
  endtask

  task automatic runMemoryProgram();
    logic [31:0] d0;
    logic [31:0] d1;
    d0 = 32'h1234_5678;
    d1 = 32'h8000_0001;
    holdReset();
    poke(32'h300, d0);
    poke(32'h304, d1);
    emit(iTypeWord(opLw, 5'd0, 5'd1, 16'h300));
    emit(iTypeWord(opLw, 5'd0, 5'd2, 16'h304));
    emit(iTypeWord(opAddi, 5'd1, 5'd1, 16'd16));
    emit(iTypeWord(opAddi, 5'd2, 5'd2, -16'sd1));
    emit(iTypeWord(opSw, 5'd0, 5'd1, 16'h310));
    emit(iTypeWord(opSw, 5'd0, 5'd2, 16'h314));
    // r0 written twice, still stores zero
    emit(iTypeWord(opAddi, 5'd0, 5'd0, 16'd55));
    emit(iTypeWord(opLw, 5'd0, 5'd0, 16'h300));
    emit(iTypeWord(opSw, 5'd0, 5'd0, 16'h318));
    // base plus positive and negative offsets
    emit(iTypeWord(opAddi, 5'd0, 5'd3, 16'h300));
    emit(iTypeWord(opLw, 5'd3, 5'd4, 16'd4));
    emit(iTypeWord(opSw, 5'd3, 5'd4, -16'sd4));
    emit(trapWord);
    expectStore(32'h310, d0 + 32'd16);
    expectStore(32'h314, d1 - 32'd1);
    expectStore(32'h318, 32'd0);
    expectStore(32'h2fc, d1);
    releaseReset();
    runUntilHalted();
    compareStoreLog();
  endtask

  task automatic loadStoreOps();
    runMemoryProgram();
  endtask

  task automatic branchAndJump();
    holdReset();
    emit(iTypeWord(opAddi, 5'd0, 5'd1, 16'd5));
    emit(iTypeWord(opAddi, 5'd0, 5'd2, 16'd5));
    emit(iTypeWord(opAddi, 5'd0, 5'd3, 16'd9));
    // 0x0c not taken, 5 vs 9
    emit(iTypeWord(opBeq, 5'd1, 5'd3, 16'd1));
    emit(iTypeWord(opSw, 5'd0, 5'd1, 16'h400));
    // 0x14 taken, lands on 0x1c
    emit(iTypeWord(opBeq, 5'd1, 5'd2, 16'd1));
    emit(iTypeWord(opSw, 5'd0, 5'd3, 16'h404));
    emit(iTypeWord(opSw, 5'd0, 5'd2, 16'h408));
    // 0x20 jumps over a marker and a trap
    emit(jumpWord(32'h2c));
    emit(iTypeWord(opSw, 5'd0, 5'd3, 16'h40c));
    emit(trapWord);
    emit(iTypeWord(opSw, 5'd0, 5'd3, 16'h410));
    emit(trapWord);
    expectStore(32'h400, 32'd5);
    expectStore(32'h408, 32'd5);
    expectStore(32'h410, 32'd9);
    releaseReset();
    runUntilHalted();
    compareStoreLog();
  endtask

  task automatic backPressure();
    maxDelay = 6;
    runMemoryProgram();
    maxDelay = 2;
  endtask

  task automatic trapHalts();
    holdReset();
    emit(iTypeWord(opAddi, 5'd0, 5'd1, 16'd3));
    emit(iTypeWord(opSw, 5'd0, 5'd1, 16'h500));
    emit(trapWord);
    emit(iTypeWord(opSw, 5'd0, 5'd1, 16'h504));
    expectStore(32'h500, 32'd3);
    releaseReset();
    runUntilHalted();
    // core must stay parked
    repeat (20) begin
      stepCycle();
      checkBit("memReq", memReq, 1'b0);
    end
    checkBit("halted", halted, 1'b1);
    compareStoreLog();
  endtask

  initial begin
    rstN     = 1'b0;
    maxDelay = 2;
    reqHeld  = 1'b0;
    void'($urandom(32'he555_ae11));
    resetAndFirstFetch();
    arithmeticOps();
    loadStoreOps();
    branchAndJump();
    backPressure();
    trapHalts();
    $display("checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* flist.f */
cpuPkg.sv
aluUnit.sv
regFile.sv
controlUnit.sv
cpuDatapath.sv
cpuTop.sv
tbMemory.sv
tbCpu.sv

/* Makefile */
# Verilator flow for the multi-cycle core and its testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tbCpu -f flist.f

sim:
	verilator --binary --timing --assert --top-module tbCpu -f flist.f -o simCpu
	./obj_dir/simCpu > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
